// ==== Makefile ====
TOP := processorTopTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f processorTop.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Word and storage sizes
`define CPU_DATA_W     16
`define CPU_REG_COUNT  16
`define CPU_ADDR_W     8
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// Opcodes
`define OP_NOP 4'd0
`define OP_ADD 4'd1
`define OP_SUB 4'd2
`define OP_AND 4'd3
`define OP_OR  4'd4
`define OP_XOR 4'd5
`define OP_SHL 4'd6
`define OP_SHR 4'd7
`define OP_MOV 4'd8
`define OP_LDI 4'd9
`define OP_LD  4'd10
`define OP_ST  4'd11
`define OP_JMP 4'd12
`define OP_JZ  4'd13
`define OP_JC  4'd14
`define OP_JR  4'd15

// Writeback source select
`define WB_ALU 2'd0
`define WB_IMM 2'd1
`define WB_MEM 2'd2

// Data memory address select
`define ADDR_DST 2'd0
`define ADDR_SRC 2'd1
`define ADDR_IMM 2'd2

// Next PC select
`define PC_INC  2'd0
`define PC_IMM  2'd1
`define PC_REG  2'd2
`define PC_HOLD 2'd3

`endif

// ==== processorTop.f ====
+incdir+include
source/cpuPkg.sv
source/registerFile.sv
source/alu.sv
source/decoder.sv
source/processor.sv
source/processorTop.sv
tb/processorTop_chk.sv
tb/processorTopTb.sv

// ==== source/alu.sv ====
`include "cpu_params.svh"

module alu (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   advance,
	input  logic [3:0]             op,
	input  logic [`CPU_DATA_W-1:0] in1,
	input  logic [`CPU_DATA_W-1:0] in2,
	output logic [`CPU_DATA_W-1:0] result,
	output logic                   cFlag,
	output logic                   zFlag
);

	// Top bit carries the carry, borrow or shifted-out bit
	logic [`CPU_DATA_W:0] wide;
	logic                 flagUpdate;

	always_comb begin
		case (op)
			`OP_ADD: wide = {1'b0, in1} + {1'b0, in2};
			`OP_SUB: wide = {1'b0, in1} - {1'b0, in2};
			`OP_AND: wide = {1'b0, in1 & in2};
			`OP_OR:  wide = {1'b0, in1 | in2};
			`OP_XOR: wide = {1'b0, in1 ^ in2};
			// Shift by one, bit falling off goes to carry
			`OP_SHL: wide = {in1, 1'b0};
			`OP_SHR: wide = {in1[0], 1'b0, in1[`CPU_DATA_W-1:1]};
			`OP_MOV: wide = {1'b0, in2};
			default: wide = '0;
		endcase
	end

	assign result = wide[`CPU_DATA_W-1:0];

	// Only ADD through SHR touch the flags
	assign flagUpdate = advance && (op >= `OP_ADD) && (op <= `OP_SHR);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagUpdate) begin
			cFlag <= wide[`CPU_DATA_W];
			zFlag <= (result == '0);
		end
	end

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

	// Register form, used by ALU ops, MOV, LD, ST and JR
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] regDst;
		logic [3:0] regSrc;
		logic [3:0] spare;
	} regForm;

	// Immediate form, used by LDI and the jumps
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] regDst;
		logic [7:0] imm;
	} immForm;

	// Same 16-bit word seen either way
	typedef union packed {
		regForm regFmt;
		immForm immFmt;
	} instrWord;

endpackage

// ==== source/decoder.sv ====
`include "cpu_params.svh"

module decoder (
	input  cpuPkg::instrWord       instr,
	input  logic                   cFlag,
	input  logic                   zFlag,
	output logic                   regWe,
	output logic [3:0]             regDst,
	output logic [3:0]             regSrc,
	output logic [1:0]             wbSel,
	output logic                   memWe,
	output logic [1:0]             addrSel,
	output logic [`CPU_DATA_W-1:0] imm,
	output logic [1:0]             pcSel,
	output logic                   halt
);

	logic [3:0] opcode;

	assign opcode = instr.regFmt.opcode;

	// imm8 is always zero-extended
	assign imm = {{(`CPU_DATA_W - 8){1'b0}}, instr.immFmt.imm};

	always_comb begin
		regWe   = 1'b0;
		regDst  = instr.regFmt.regDst;
		regSrc  = instr.regFmt.regSrc;
		wbSel   = `WB_ALU;
		memWe   = 1'b0;
		addrSel = `ADDR_IMM;
		pcSel   = `PC_INC;
		halt    = 1'b0;

		case (opcode)
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_SHL, `OP_SHR, `OP_MOV: begin
				regWe = 1'b1;
			end
			`OP_LDI: begin
				regWe  = 1'b1;
				wbSel  = `WB_IMM;
			end
			`OP_LD: begin
				regWe   = 1'b1;
				wbSel   = `WB_MEM;
				addrSel = `ADDR_SRC;
			end
			`OP_ST: begin
				memWe   = 1'b1;
				addrSel = `ADDR_DST;
			end
			`OP_JMP: begin
				pcSel = `PC_IMM;
			end
			// Conditional jumps fall through when the flag is clear
			`OP_JZ: begin
				pcSel = zFlag ? `PC_IMM : `PC_INC;
			end
			`OP_JC: begin
				pcSel = cFlag ? `PC_IMM : `PC_INC;
			end
			`OP_JR: begin
				// JR through r15 means HALT
				if (instr.regFmt.regSrc == 4'hf) begin
					halt  = 1'b1;
					pcSel = `PC_HOLD;
				end else begin
					pcSel = `PC_REG;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== source/processor.sv ====
`include "cpu_params.svh"

module processor (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   advance,
	input  cpuPkg::instrWord       instr,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic                   regWe,
	output logic [3:0]             regWaddr,
	output logic [`CPU_DATA_W-1:0] regWdata,
	output logic                   memWe,
	output logic [`CPU_DATA_W-1:0] memAddr,
	output logic [`CPU_DATA_W-1:0] memWdata,
	output logic                   halted
);

	logic                   decRegWe;
	logic                   decMemWe;
	logic [3:0]             regDst;
	logic [3:0]             regSrc;
	logic [1:0]             wbSel;
	logic [1:0]             addrSel;
	logic [1:0]             pcSel;
	logic                   halt;
	logic [`CPU_DATA_W-1:0] imm;
	logic [`CPU_DATA_W-1:0] dstData;
	logic [`CPU_DATA_W-1:0] srcData;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic [`CPU_DATA_W-1:0] memRdata;
	logic [`CPU_DATA_W-1:0] nextPc;
	logic                   cFlag;
	logic                   zFlag;

	logic [`CPU_DATA_W-1:0] dataMem [`CPU_DMEM_DEPTH];

	registerFile regFile (
		.clk(clk),
		.rst(rst),
		.we(regWe),
		.waddr(regWaddr),
		.wdata(regWdata),
		.raddrA(regDst),
		.rdataA(dstData),
		.raddrB(regSrc),
		.rdataB(srcData)
	);

	alu aluUnit (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.op(instr.regFmt.opcode),
		.in1(dstData),
		.in2(srcData),
		.result(aluResult),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	decoder decode (
		.instr(instr),
		.cFlag(cFlag),
		.zFlag(zFlag),
		.regWe(decRegWe),
		.regDst(regDst),
		.regSrc(regSrc),
		.wbSel(wbSel),
		.memWe(decMemWe),
		.addrSel(addrSel),
		.imm(imm),
		.pcSel(pcSel),
		.halt(halt)
	);

	// Strobes only while the core is stepping
	assign regWe    = decRegWe & advance;
	assign memWe    = decMemWe & advance;
	assign regWaddr = regDst;
	assign memWdata = srcData;

	always_comb begin
		case (addrSel)
			`ADDR_DST: memAddr = dstData;
			`ADDR_SRC: memAddr = srcData;
			default:   memAddr = imm;
		endcase
	end

	always_comb begin
		case (wbSel)
			`WB_IMM: regWdata = imm;
			`WB_MEM: regWdata = memRdata;
			default: regWdata = aluResult;
		endcase
	end

	// Data memory, word addressed by the low address bits
	always_ff @(posedge clk) begin
		if (memWe) begin
			dataMem[memAddr[`CPU_ADDR_W-1:0]] <= memWdata;
		end
	end

	assign memRdata = dataMem[memAddr[`CPU_ADDR_W-1:0]];

	always_comb begin
		case (pcSel)
			`PC_IMM:  nextPc = imm;
			`PC_REG:  nextPc = srcData;
			`PC_HOLD: nextPc = pc;
			default:  nextPc = pc + 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (advance) begin
			pc <= nextPc;
			if (halt) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

// ==== source/processorTop.sv ====
`include "cpu_params.svh"

module processorTop (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   progWe,
	input  logic [`CPU_ADDR_W-1:0] progAddr,
	input  cpuPkg::instrWord       progData,
	input  logic                   run,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic                   regWe,
	output logic [3:0]             regWaddr,
	output logic [`CPU_DATA_W-1:0] regWdata,
	output logic                   memWe,
	output logic [`CPU_DATA_W-1:0] memAddr,
	output logic [`CPU_DATA_W-1:0] memWdata,
	output logic                   halted
);

	cpuPkg::instrWord instrMem [`CPU_IMEM_DEPTH];
	cpuPkg::instrWord instr;
	logic             advance;

	// Program load port
	always_ff @(posedge clk) begin
		if (progWe) begin
			instrMem[progAddr] <= progData;
		end
	end

	assign instr = instrMem[pc[`CPU_ADDR_W-1:0]];

	// Stall while run is low, stop for good once halted
	assign advance = run & ~halted;

	processor cpu (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.instr(instr),
		.pc(pc),
		.regWe(regWe),
		.regWaddr(regWaddr),
		.regWdata(regWdata),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.halted(halted)
	);

endmodule

// ==== source/registerFile.sv ====
`include "cpu_params.svh"

module registerFile (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   we,
	input  logic [3:0]             waddr,
	input  logic [`CPU_DATA_W-1:0] wdata,
	input  logic [3:0]             raddrA,
	output logic [`CPU_DATA_W-1:0] rdataA,
	input  logic [3:0]             raddrB,
	output logic [`CPU_DATA_W-1:0] rdataB
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Reads see the value from before this cycle's write
	assign rdataA = regs[raddrA];
	assign rdataB = regs[raddrB];

endmodule

// ==== tb/processorTopTb.sv ====
`include "cpu_params.svh"

module processorTopTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int MAX_ROWS = 64;
	localparam int EV_NONE = 0;
	localparam int EV_REG = 1;
	localparam int EV_MEM = 2;

	logic                   clk;
	logic                   rst;
	logic                   progWe;
	logic [`CPU_ADDR_W-1:0] progAddr;
	cpuPkg::instrWord       progData;
	logic                   run;
	logic [`CPU_DATA_W-1:0] pc;
	logic                   regWe;
	logic [3:0]             regWaddr;
	logic [`CPU_DATA_W-1:0] regWdata;
	logic                   memWe;
	logic [`CPU_DATA_W-1:0] memAddr;
	logic [`CPU_DATA_W-1:0] memWdata;
	logic                   halted;

	// One row per program word with its expected retire event
	cpuPkg::instrWord       rowInstr [MAX_ROWS];
	int                     rowKind [MAX_ROWS];
	logic [`CPU_DATA_W-1:0] rowWhere [MAX_ROWS];
	logic [`CPU_DATA_W-1:0] rowValue [MAX_ROWS];
	int                     groupStart [8];
	int                     groupLen [8];
	logic [`CPU_DATA_W-1:0] groupHalt [8];
	int                     rowCount = 0;
	int                     groupCount = 0;
	bit                     tableReady = 1'b0;
	logic [31:0]            lcgState = 32'h36e9423f;
	int                     errorCount = 0;
	int                     passCount = 0;
	int                     testErrors;
	int                     assertFails;

	processorTop processorTop_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [7:0] nextOperand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[23:16];
	endfunction

	function automatic cpuPkg::instrWord regInstr(input logic [3:0] op, input logic [3:0] dst,
			input logic [3:0] src);
		cpuPkg::instrWord w;
		w.regFmt = '{opcode: op, regDst: dst, regSrc: src, spare: 4'h0};
		return w;
	endfunction

	function automatic cpuPkg::instrWord immInstr(input logic [3:0] op, input logic [3:0] dst,
			input logic [7:0] imm);
		cpuPkg::instrWord w;
		w.immFmt = '{opcode: op, regDst: dst, imm: imm};
		return w;
	endfunction

	task automatic addRow(input cpuPkg::instrWord w, input int kind,
			input logic [`CPU_DATA_W-1:0] where, input logic [`CPU_DATA_W-1:0] value);
		rowInstr[rowCount] = w;
		rowKind[rowCount] = kind;
		rowWhere[rowCount] = where;
		rowValue[rowCount] = value;
		rowCount++;
	endtask

	task automatic closeGroup(input logic [`CPU_DATA_W-1:0] haltAddr);
		groupLen[groupCount] = rowCount - groupStart[groupCount];
		groupHalt[groupCount] = haltAddr;
		groupCount++;
		groupStart[groupCount] = rowCount;
	endtask

	task automatic buildTable();
		logic [7:0]             a;
		logic [7:0]             b;
		logic [`CPU_DATA_W-1:0] x1;
		logic [`CPU_DATA_W-1:0] x2;
		// ALU program, x1 and x2 follow r1 and r2
		a = nextOperand();
		b = nextOperand();
		x1 = {8'h00, a};
		x2 = {8'h00, b};
		addRow(immInstr(`OP_LDI, 4'd1, a), EV_REG, 16'd1, x1);
		addRow(immInstr(`OP_LDI, 4'd2, b), EV_REG, 16'd2, x2);
		x1 = x1 + x2;
		addRow(regInstr(`OP_ADD, 4'd1, 4'd2), EV_REG, 16'd1, x1);
		x2 = x2 - x1;
		addRow(regInstr(`OP_SUB, 4'd2, 4'd1), EV_REG, 16'd2, x2);
		x1 = x1 | x2;
		addRow(regInstr(`OP_OR, 4'd1, 4'd2), EV_REG, 16'd1, x1);
		x2 = x2 ^ x1;
		addRow(regInstr(`OP_XOR, 4'd2, 4'd1), EV_REG, 16'd2, x2);
		x1 = x1 << 1;
		addRow(regInstr(`OP_SHL, 4'd1, 4'd0), EV_REG, 16'd1, x1);
		x2 = x2 >> 1;
		addRow(regInstr(`OP_SHR, 4'd2, 4'd0), EV_REG, 16'd2, x2);
		x1 = x1 & x2;
		addRow(regInstr(`OP_AND, 4'd1, 4'd2), EV_REG, 16'd1, x1);
		addRow(regInstr(`OP_MOV, 4'd3, 4'd1), EV_REG, 16'd3, x1);
		addRow(regInstr(`OP_JR, 4'd0, 4'd15), EV_NONE, 16'd0, 16'd0);
		closeGroup(16'd10);
		// Branches, first SUB gives Z=1 C=0, second one borrows
		a = nextOperand() | 8'h01;
		b = nextOperand() | 8'h01;
		addRow(immInstr(`OP_LDI, 4'd1, a), EV_REG, 16'd1, {8'h00, a});
		addRow(regInstr(`OP_SUB, 4'd1, 4'd1), EV_REG, 16'd1, 16'd0);
		addRow(immInstr(`OP_JZ, 4'd0, 8'd4), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_LDI, 4'd2, 8'h11), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_JC, 4'd0, 8'd6), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_LDI, 4'd2, b), EV_REG, 16'd2, {8'h00, b});
		addRow(regInstr(`OP_SUB, 4'd1, 4'd2), EV_REG, 16'd1, 16'd0 - {8'h00, b});
		// LDI in between must keep Z=0 C=1
		addRow(immInstr(`OP_LDI, 4'd4, b), EV_REG, 16'd4, {8'h00, b});
		addRow(immInstr(`OP_JZ, 4'd0, 8'd10), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_JC, 4'd0, 8'd11), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_LDI, 4'd5, 8'h33), EV_NONE, 16'd0, 16'd0);
		addRow(regInstr(`OP_JR, 4'd0, 4'd15), EV_NONE, 16'd0, 16'd0);
		closeGroup(16'd11);
		// Store then load back
		a = nextOperand();
		b = nextOperand();
		addRow(immInstr(`OP_LDI, 4'd1, a), EV_REG, 16'd1, {8'h00, a});
		addRow(immInstr(`OP_LDI, 4'd2, b), EV_REG, 16'd2, {8'h00, b});
		addRow(regInstr(`OP_ST, 4'd1, 4'd2), EV_MEM, {8'h00, a}, {8'h00, b});
		addRow(regInstr(`OP_LD, 4'd3, 4'd1), EV_REG, 16'd3, {8'h00, b});
		addRow(regInstr(`OP_JR, 4'd0, 4'd15), EV_NONE, 16'd0, 16'd0);
		closeGroup(16'd4);
		// JMP and JR skip words, last word lies past HALT
		a = nextOperand();
		addRow(immInstr(`OP_LDI, 4'd6, 8'd5), EV_REG, 16'd6, 16'd5);
		addRow(immInstr(`OP_JMP, 4'd0, 8'd3), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_LDI, 4'd7, 8'h77), EV_NONE, 16'd0, 16'd0);
		addRow(regInstr(`OP_JR, 4'd0, 4'd6), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_LDI, 4'd7, 8'h66), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_LDI, 4'd8, a), EV_REG, 16'd8, {8'h00, a});
		addRow(regInstr(`OP_JR, 4'd0, 4'd15), EV_NONE, 16'd0, 16'd0);
		addRow(immInstr(`OP_LDI, 4'd9, 8'h99), EV_NONE, 16'd0, 16'd0);
		closeGroup(16'd6);
	endtask

	task automatic checkValue(input string name, input logic [`CPU_DATA_W-1:0] expected,
			input logic [`CPU_DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("error at %0t ns: %s", $time, what);
		testErrors++;
	endtask

	task automatic compareReg(input logic [3:0] expIdx, input logic [`CPU_DATA_W-1:0] expVal);
		checkValue("regWaddr", {12'h000, expIdx}, {12'h000, regWaddr});
		checkValue("regWdata", expVal, regWdata);
	endtask

	task automatic compareMem(input logic [`CPU_DATA_W-1:0] expAddr,
			input logic [`CPU_DATA_W-1:0] expVal);
		checkValue("memAddr", expAddr, memAddr);
		checkValue("memWdata", expVal, memWdata);
	endtask

	task automatic comparePc(input logic [`CPU_DATA_W-1:0] expPc);
		checkValue("pc", expPc, pc);
	endtask

	task automatic runTest(input int g);
		int r;
		int last;
		int cycles;
		testErrors = 0;
		r = groupStart[g];
		last = groupStart[g] + groupLen[g];
		@(posedge clk);
		rst <= 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// Load with run low, core must stay idle at pc 0
		for (int i = 0; i < groupLen[g]; i++) begin
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= 8'(i);
			progData <= rowInstr[r + i];
			@(negedge clk);
			if (regWe || memWe)
				reportFailure("write strobe while loading");
			comparePc(16'd0);
		end
		@(posedge clk);
		progWe <= 1'b0;
		run <= 1'b1;
		// Strobes are sampled mid-cycle, before the retiring edge
		for (cycles = 0; cycles < 4 * groupLen[g] && !halted; cycles++) begin
			@(negedge clk);
			if (regWe || memWe) begin
				while (r < last && rowKind[r] == EV_NONE)
					r++;
				if (r >= last)
					reportFailure("write strobe beyond the expected events");
				else if (regWe && rowKind[r] == EV_REG)
					compareReg(rowWhere[r][3:0], rowValue[r]);
				else if (memWe && rowKind[r] == EV_MEM)
					compareMem(rowWhere[r], rowValue[r]);
				else
					reportFailure("write strobe of the wrong kind");
				r++;
			end
		end
		while (r < last && rowKind[r] == EV_NONE)
			r++;
		if (!halted)
			reportFailure("program did not reach HALT");
		if (r < last)
			reportFailure("expected writes never appeared");
		comparePc(groupHalt[g]);
		repeat (3) begin
			@(negedge clk);
			if (regWe || memWe)
				reportFailure("write strobe after HALT");
			comparePc(groupHalt[g]);
		end
		@(posedge clk);
		run <= 1'b0;
		if (testErrors == 0) begin
			passCount++;
			$display("test %0d passed", g);
		end else begin
			$display("test %0d failed with %0d errors", g, testErrors);
		end
		errorCount += testErrors;
	endtask

	initial begin
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		run = 1'b0;
		groupStart[0] = 0;
		buildTable();
		tableReady = 1'b1;
		for (int g = 0; g < groupCount; g++)
			runTest(g);
		assertFails = processorTop_i.processorTop_chk_i.failCount;
		errorCount += assertFails;
		$display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures, %0d errors",
			groupCount, passCount, groupCount - passCount, assertFails, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Eight cycles for every table row
	initial begin
		wait (tableReady);
		#(rowCount * 8 * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d cycles", rowCount * 8);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== tb/processorTop_chk.sv ====
`include "cpu_params.svh"

module processorTop_chk (
	input logic                   clk,
	input logic                   rst,
	input logic                   run,
	input logic                   regWe,
	input logic                   memWe,
	input logic [`CPU_DATA_W-1:0] pc,
	input logic                   halted
);

	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	// Stalled core must not write
	stoppedQuiet: assert property (@(posedge clk) disable iff (rst) !run |-> !regWe && !memWe)
		else begin
			failCount++;
			$error("write strobe seen while run is low");
		end

	haltFreezesPc: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
		else begin
			failCount++;
			$error("pc moved while halted");
		end

	oneWritePerCycle: assert property (@(posedge clk) disable iff (rst) !(regWe && memWe))
		else begin
			failCount++;
			$error("register and memory write in the same cycle");
		end

endmodule

bind processorTop processorTop_chk processorTop_chk_i (
	.clk(clk),
	.rst(rst),
	.run(run),
	.regWe(regWe),
	.memWe(memWe),
	.pc(pc),
	.halted(halted)
);
